// File: include/id_ctrl_params.svh
// ID stage controller sizes, type codes and uop costs, included by the package and RTL
`ifndef ID_CTRL_PARAMS_SVH
`define ID_CTRL_PARAMS_SVH

// stage geometry
`define ID_CTRL_SLOTS 4
`define ID_CTRL_LANES 4

// width of one instruction type code
`define ID_CTRL_TYPE_W 2

// instruction type classes as delivered by the IB
`define ID_CTRL_TYPE_NORMAL      2'd0
`define ID_CTRL_TYPE_SPLIT_SHORT 2'd1
`define ID_CTRL_TYPE_SPLIT_LONG  2'd2
`define ID_CTRL_TYPE_FENCE       2'd3

// IR lanes consumed per instruction in prefix packing
`define ID_CTRL_COST_NORMAL 1
`define ID_CTRL_COST_SHORT  2

`endif

// File: source/id_ctrl_pkg.sv
// Shared vector types of the ID stage controller, referenced by scoped name from RTL and testbench
`default_nettype none
`include "id_ctrl_params.svh"

package id_ctrl_pkg;

  // one valid bit per ID slot, slot 0 lowest
  typedef logic [`ID_CTRL_SLOTS-1:0] slot_vld_t;

  // a single type code
  typedef logic [`ID_CTRL_TYPE_W-1:0] inst_type_t;

  // all slot type codes packed, slot 0 in the low bits
  typedef logic [`ID_CTRL_SLOTS*`ID_CTRL_TYPE_W-1:0] slot_types_t;

  // IR uop lane valid mask
  typedef logic [`ID_CTRL_LANES-1:0] uop_vld_t;

  // instructions leaving ID in one cycle, 0 to 4
  typedef logic [2:0] pipedown_cnt_t;

endpackage

`default_nettype wire

// File: source/id_decode_slots.sv
// ID slot registers; loads IB bundles, shifts down after partial pipedown, holds or flushes
`default_nettype none
`include "id_ctrl_params.svh"

module id_decode_slots (
  input  wire                       debug_id_inst_clk,
  input  wire                       cpurst_b,
  input  wire                       rtu_flush,
  input  wire                       iu_cancel,
  input  wire id_ctrl_pkg::slot_vld_t     ib_inst_vld,
  input  wire id_ctrl_pkg::slot_types_t   ib_inst_types,
  input  wire                       id_stall,
  input  wire                       pipedown_stall,
  input  wire id_ctrl_pkg::pipedown_cnt_t pipedown_cnt,
  output id_ctrl_pkg::slot_vld_t          slot_vld,
  output id_ctrl_pkg::slot_types_t        slot_types
);

  id_ctrl_pkg::slot_vld_t   shift_vld;
  id_ctrl_pkg::slot_types_t shift_types;
  id_ctrl_pkg::slot_vld_t   vld_nxt;
  id_ctrl_pkg::slot_types_t types_nxt;

  //----------------------------------------------------------------------
  // shift down by the number of instructions that left
  //----------------------------------------------------------------------
  // vacated top slots fill with zero valids
  assign shift_vld   = slot_vld >> pipedown_cnt;
  assign shift_types = slot_types >> (pipedown_cnt * `ID_CTRL_TYPE_W);

  //----------------------------------------------------------------------
  // next slot contents
  //----------------------------------------------------------------------
  always_comb begin
    vld_nxt   = slot_vld;
    types_nxt = slot_types;
    if (!id_stall) begin
      // whole ID drains this cycle, take the IB bundle (may be empty)
      vld_nxt   = ib_inst_vld;
      types_nxt = ib_inst_types;
    end
    else if (!pipedown_stall) begin
      // partial pipedown, remaining slots move toward slot 0
      vld_nxt   = shift_vld;
      types_nxt = shift_types;
    end
  end

  // valid bits, flush has top priority
  always_ff @(posedge debug_id_inst_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      slot_vld <= '0;
    end
    else if (rtu_flush || iu_cancel) begin
      slot_vld <= '0;
    end
    else begin
      slot_vld <= vld_nxt;
    end
  end

  // type codes, meaningful only where the matching valid bit is set
  always_ff @(posedge debug_id_inst_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      slot_types <= '0;
    end
    else begin
      slot_types <= types_nxt;
    end
  end

endmodule

`default_nettype wire

// File: source/id_pipedown_sel.sv
// Pipedown selection; count and IR lane mask from slot types, plus every ID stall condition
`default_nettype none
`include "id_ctrl_params.svh"

module id_pipedown_sel (
  input  wire id_ctrl_pkg::slot_vld_t   slot_vld,
  input  wire id_ctrl_pkg::slot_types_t slot_types,
  input  wire                     ir_stall,
  input  wire                     ir_stage_stall,
  input  wire                     fence_stall,
  input  wire id_ctrl_pkg::uop_vld_t    fence_uop_vld,
  input  wire                     split_long_stall,
  input  wire id_ctrl_pkg::uop_vld_t    split_long_uop_vld,
  output id_ctrl_pkg::pipedown_cnt_t    pipedown_cnt,
  output id_ctrl_pkg::uop_vld_t         ir_uop_vld,
  output logic                    pipedown_stall,
  output logic                    id_stall,
  output logic                    fence_inst_vld,
  output logic                    split_long_inst_vld,
  output logic                    had_pipe_stall
);

  id_ctrl_pkg::inst_type_t    slot_type [`ID_CTRL_SLOTS];
  logic [`ID_CTRL_SLOTS-1:0]  slot_pack;
  logic [1:0]                 slot_cost [`ID_CTRL_SLOTS];
  id_ctrl_pkg::pipedown_cnt_t pack_cnt;
  logic [2:0]                 pack_cost;
  id_ctrl_pkg::uop_vld_t      pack_lanes;
  id_ctrl_pkg::pipedown_cnt_t vld_cnt;

  //----------------------------------------------------------------------
  // per-slot classification
  //----------------------------------------------------------------------
  for (genvar i = 0; i < `ID_CTRL_SLOTS; i++) begin : g_slot
    assign slot_type[i] = slot_types[i*`ID_CTRL_TYPE_W +: `ID_CTRL_TYPE_W];
    // normal and short split can share a cycle with neighbours
    assign slot_pack[i] = slot_vld[i]
                          && (slot_type[i] == `ID_CTRL_TYPE_NORMAL
                           || slot_type[i] == `ID_CTRL_TYPE_SPLIT_SHORT);
    assign slot_cost[i] = (slot_type[i] == `ID_CTRL_TYPE_SPLIT_SHORT) ?
                          2'(`ID_CTRL_COST_SHORT) : 2'(`ID_CTRL_COST_NORMAL);
  end

  // slot 0 helpers
  assign fence_inst_vld      = slot_vld[0] && (slot_type[0] == `ID_CTRL_TYPE_FENCE);
  assign split_long_inst_vld = slot_vld[0] && (slot_type[0] == `ID_CTRL_TYPE_SPLIT_LONG);

  //----------------------------------------------------------------------
  // prefix packing
  //----------------------------------------------------------------------
  // longest run from slot 0 that fits the IR lanes
  always_comb begin
    logic run;
    run       = 1'b1;
    pack_cnt  = '0;
    pack_cost = '0;
    for (int i = 0; i < `ID_CTRL_SLOTS; i++) begin
      if (run && slot_pack[i] && ({1'b0, pack_cost} + slot_cost[i] <= `ID_CTRL_LANES)) begin
        pack_cnt  = pack_cnt + 3'd1;
        pack_cost = pack_cost + {1'b0, slot_cost[i]};
      end
      else begin
        // fence, long split or empty slot ends the run
        run = 1'b0;
      end
    end
  end

  // lowest pack_cost lanes set
  assign pack_lanes = ~({`ID_CTRL_LANES{1'b1}} << pack_cost);

  // valid slots are contiguous, so this is the occupancy
  always_comb begin
    vld_cnt = '0;
    for (int i = 0; i < `ID_CTRL_SLOTS; i++) begin
      vld_cnt = vld_cnt + {2'b00, slot_vld[i]};
    end
  end

  //----------------------------------------------------------------------
  // stalls
  //----------------------------------------------------------------------
  assign pipedown_stall = slot_vld[0]
                          && (ir_stall
                           || (fence_inst_vld && fence_stall)
                           || (split_long_inst_vld && split_long_stall));

  // fence and long split own the whole IR stage
  always_comb begin
    if (pipedown_stall) begin
      pipedown_cnt = '0;
      ir_uop_vld   = '0;
    end
    else if (fence_inst_vld) begin
      pipedown_cnt = 3'd1;
      ir_uop_vld   = fence_uop_vld;
    end
    else if (split_long_inst_vld) begin
      pipedown_cnt = 3'd1;
      ir_uop_vld   = split_long_uop_vld;
    end
    else begin
      pipedown_cnt = pack_cnt;
      ir_uop_vld   = pack_lanes;
    end
  end

  // IB must hold unless everything in ID leaves now
  assign id_stall = slot_vld[0] && (pipedown_stall || (pipedown_cnt < vld_cnt));

  assign had_pipe_stall = ir_stage_stall || (fence_inst_vld && fence_stall);

endmodule

`default_nettype wire

// File: source/id_debug_track.sv
// Debug and performance-counter tracking of ID drains and the bundle seen after each drain
`default_nettype none

module id_debug_track (
  input  wire                     debug_id_inst_clk,
  input  wire                     cpurst_b,
  input  wire id_ctrl_pkg::slot_vld_t   slot_vld,
  input  wire                     id_stall,
  input  wire                     had_debug_en,
  input  wire                     hpcp_cnt_en,
  output id_ctrl_pkg::slot_vld_t        had_inst_vld,
  output logic                    hpcp_backend_stall
);

  logic debug_pipedown;
  logic debug_watch;

  //----------------------------------------------------------------------
  // full drain flag
  //----------------------------------------------------------------------
  // only tracked while debug or counters are watching
  assign debug_watch = slot_vld[0] && (had_debug_en || hpcp_cnt_en);

  always_ff @(posedge debug_id_inst_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      debug_pipedown <= 1'b0;
    end
    else begin
      debug_pipedown <= debug_watch && !id_stall;
    end
  end

  // backend counted as stalled whenever ID did not drain
  assign hpcp_backend_stall = !debug_pipedown;

  //----------------------------------------------------------------------
  // slot valids observed after a drain
  //----------------------------------------------------------------------
  always_ff @(posedge debug_id_inst_clk or negedge cpurst_b) begin
    if (!cpurst_b) begin
      had_inst_vld <= '0;
    end
    else if (debug_pipedown) begin
      had_inst_vld <= slot_vld;
    end
    else begin
      had_inst_vld <= '0;
    end
  end

endmodule

`default_nettype wire

// File: source/id_ctrl_top.sv
// Top of the ID stage controller, connecting slot storage, pipedown selection and debug tracking
`default_nettype none

module id_ctrl_top (
  input  wire                     debug_id_inst_clk,
  input  wire                     cpurst_b,
  // flush and cancel
  input  wire                     rtu_flush,
  input  wire                     iu_cancel,
  // instruction buffer
  input  wire id_ctrl_pkg::slot_vld_t   ib_inst_vld,
  input  wire id_ctrl_pkg::slot_types_t ib_inst_types,
  output logic                    id_stall,
  // issue stage
  input  wire                     ir_stall,
  input  wire                     ir_stage_stall,
  output id_ctrl_pkg::pipedown_cnt_t    pipedown_cnt,
  output id_ctrl_pkg::uop_vld_t         ir_uop_vld,
  // fence helper
  input  wire                     fence_stall,
  input  wire id_ctrl_pkg::uop_vld_t    fence_uop_vld,
  output logic                    fence_inst_vld,
  // long split helper
  input  wire                     split_long_stall,
  input  wire id_ctrl_pkg::uop_vld_t    split_long_uop_vld,
  output logic                    split_long_inst_vld,
  // debug and counters
  input  wire                     had_debug_en,
  input  wire                     hpcp_cnt_en,
  output logic                    had_pipe_stall,
  output id_ctrl_pkg::slot_vld_t        had_inst_vld,
  output logic                    hpcp_backend_stall
);

  id_ctrl_pkg::slot_vld_t   slot_vld;
  id_ctrl_pkg::slot_types_t slot_types;
  logic                     pipedown_stall;

  //----------------------------------------------------------------------
  // slot storage
  //----------------------------------------------------------------------
  id_decode_slots u_decode (
    .debug_id_inst_clk (debug_id_inst_clk),
    .cpurst_b          (cpurst_b),
    .rtu_flush         (rtu_flush),
    .iu_cancel         (iu_cancel),
    .ib_inst_vld       (ib_inst_vld),
    .ib_inst_types     (ib_inst_types),
    .id_stall          (id_stall),
    .pipedown_stall    (pipedown_stall),
    .pipedown_cnt      (pipedown_cnt),
    .slot_vld          (slot_vld),
    .slot_types        (slot_types)
  );

  //----------------------------------------------------------------------
  // pipedown and stalls
  //----------------------------------------------------------------------
  id_pipedown_sel u_execute (
    .slot_vld            (slot_vld),
    .slot_types          (slot_types),
    .ir_stall            (ir_stall),
    .ir_stage_stall      (ir_stage_stall),
    .fence_stall         (fence_stall),
    .fence_uop_vld       (fence_uop_vld),
    .split_long_stall    (split_long_stall),
    .split_long_uop_vld  (split_long_uop_vld),
    .pipedown_cnt        (pipedown_cnt),
    .ir_uop_vld          (ir_uop_vld),
    .pipedown_stall      (pipedown_stall),
    .id_stall            (id_stall),
    .fence_inst_vld      (fence_inst_vld),
    .split_long_inst_vld (split_long_inst_vld),
    .had_pipe_stall      (had_pipe_stall)
  );

  // debug observation
  id_debug_track u_result (
    .debug_id_inst_clk  (debug_id_inst_clk),
    .cpurst_b           (cpurst_b),
    .slot_vld           (slot_vld),
    .id_stall           (id_stall),
    .had_debug_en       (had_debug_en),
    .hpcp_cnt_en        (hpcp_cnt_en),
    .had_inst_vld       (had_inst_vld),
    .hpcp_backend_stall (hpcp_backend_stall)
  );

endmodule

`default_nettype wire

// File: testbench/tb_id_ctrl.sv
// Directed testbench for the ID stage controller; acts as IB and IR and checks against a slot model
`default_nettype none
`include "id_ctrl_params.svh"

module tb_id_ctrl;

  localparam int NUM_TESTS   = 6;
  localparam int WATCHDOG_NS = (NUM_TESTS * 40 + 20) * 10;

  logic debug_id_inst_clk, cpurst_b, rtu_flush, iu_cancel;
  logic ir_stall, ir_stage_stall, fence_stall, split_long_stall;
  logic had_debug_en, hpcp_cnt_en;
  logic id_stall, fence_inst_vld, split_long_inst_vld, had_pipe_stall, hpcp_backend_stall;
  id_ctrl_pkg::slot_vld_t     ib_inst_vld, had_inst_vld;
  id_ctrl_pkg::slot_types_t   ib_inst_types;
  id_ctrl_pkg::uop_vld_t      fence_uop_vld, split_long_uop_vld, ir_uop_vld;
  id_ctrl_pkg::pipedown_cnt_t pipedown_cnt;

  // model of the slots and the debug registers
  id_ctrl_pkg::slot_vld_t   m_vld, m_had;
  id_ctrl_pkg::slot_types_t m_types;
  logic                     m_dbg;
  logic [7:0]               lfsr;
  string                    test_name;
  int                       test_errors, errors, failed_tests;

  id_ctrl_top dut0 (.*);

  initial begin
    debug_id_inst_clk = 1'b0;
    forever #5 debug_id_inst_clk = ~debug_id_inst_clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired, the tests did not complete in time");
    $display("TEST FAILED");
    $finish;
  end

  // 8-bit Galois LFSR, one step per bit taken
  function automatic logic lfsr_bit();
    logic out;
    out  = lfsr[0];
    lfsr = lfsr >> 1;
    if (out) lfsr = lfsr ^ 8'hb8;
    return out;
  endfunction

  task automatic check_value(input string what, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp) begin
      $display("Error %s %s: expected %0h, actual %0h", test_name, what, exp, act);
      test_errors++;
    end
  endtask

  //----------------------------------------------------------------------
  // pipedown rule applied to the model slots
  //----------------------------------------------------------------------
  task automatic predict(output id_ctrl_pkg::pipedown_cnt_t cnt,
                         output id_ctrl_pkg::uop_vld_t lanes,
                         output logic pstall, output logic istall);
    id_ctrl_pkg::inst_type_t t0, t;
    int cost, n, c;
    t0     = m_types[1:0];
    pstall = m_vld[0] && (ir_stall || (t0 == `ID_CTRL_TYPE_FENCE && fence_stall)
                          || (t0 == `ID_CTRL_TYPE_SPLIT_LONG && split_long_stall));
    cnt    = '0;
    lanes  = '0;
    if (!pstall && m_vld[0] && t0 == `ID_CTRL_TYPE_FENCE) begin
      cnt   = 3'd1;
      lanes = fence_uop_vld;
    end
    else if (!pstall && m_vld[0] && t0 == `ID_CTRL_TYPE_SPLIT_LONG) begin
      cnt   = 3'd1;
      lanes = split_long_uop_vld;
    end
    else if (!pstall) begin
      cost = 0;
      n    = 0;
      while (n < `ID_CTRL_SLOTS && m_vld[n]) begin
        t = m_types[2*n +: 2];
        if (t != `ID_CTRL_TYPE_NORMAL && t != `ID_CTRL_TYPE_SPLIT_SHORT) break;
        c = (t == `ID_CTRL_TYPE_SPLIT_SHORT) ? `ID_CTRL_COST_SHORT : `ID_CTRL_COST_NORMAL;
        if (cost + c > `ID_CTRL_LANES) break;
        cost += c;
        n++;
      end
      cnt   = 3'(n);
      lanes = 4'((1 << cost) - 1);
    end
    istall = m_vld[0] && (pstall || cnt < $countones(m_vld));
  endtask

  // one clock cycle, entered and left at a falling edge
  task automatic step_cycle(output logic accepted);
    id_ctrl_pkg::pipedown_cnt_t e_cnt;
    id_ctrl_pkg::uop_vld_t      e_lanes;
    logic                       e_pstall, e_istall, e_fence, e_long;
    #1;
    predict(e_cnt, e_lanes, e_pstall, e_istall);
    e_fence = m_vld[0] && m_types[1:0] == `ID_CTRL_TYPE_FENCE;
    e_long  = m_vld[0] && m_types[1:0] == `ID_CTRL_TYPE_SPLIT_LONG;
    check_value("pipedown_cnt", e_cnt, pipedown_cnt);
    check_value("ir_uop_vld", e_lanes, ir_uop_vld);
    check_value("id_stall", e_istall, id_stall);
    check_value("fence_inst_vld", e_fence, fence_inst_vld);
    check_value("split_long_inst_vld", e_long, split_long_inst_vld);
    check_value("had_pipe_stall", ir_stage_stall || (e_fence && fence_stall), had_pipe_stall);
    check_value("hpcp_backend_stall", !m_dbg, hpcp_backend_stall);
    check_value("had_inst_vld", m_had, had_inst_vld);
    accepted = !(rtu_flush || iu_cancel) && !e_istall && ib_inst_vld != '0;
    m_had    = m_dbg ? m_vld : '0;
    m_dbg    = m_vld[0] && (had_debug_en || hpcp_cnt_en) && !e_istall;
    if (rtu_flush || iu_cancel) begin
      m_vld = '0;
    end
    else if (!e_istall) begin
      m_vld   = ib_inst_vld;
      m_types = ib_inst_types;
    end
    else if (!e_pstall) begin
      m_vld   = m_vld >> e_cnt;
      m_types = m_types >> (2 * e_cnt);
    end
    @(negedge debug_id_inst_clk);
  endtask

  // IB side, bundle held until ID takes it
  task automatic feed_bundle(input id_ctrl_pkg::slot_vld_t vld,
                             input id_ctrl_pkg::slot_types_t types);
    logic accepted;
    ib_inst_vld   = vld;
    ib_inst_types = types;
    accepted      = 1'b0;
    while (!accepted) step_cycle(accepted);
    ib_inst_vld   = '0;
  endtask

  task automatic drain_slots();
    logic accepted;
    while (m_vld != '0) step_cycle(accepted);
  endtask

  task automatic finish_test();
    if (test_errors == 0) begin
      $display("test %s: ok", test_name);
    end
    else begin
      $display("test %s: %0d errors", test_name, test_errors);
      failed_tests++;
    end
    errors += test_errors;
    test_errors = 0;
  endtask

  //----------------------------------------------------------------------
  // directed tests
  //----------------------------------------------------------------------
  task automatic test_reset();
    logic accepted;
    test_name = "reset";
    check_value("hpcp_backend_stall", 1'b1, hpcp_backend_stall);
    repeat (2) step_cycle(accepted);
    finish_test();
  endtask

  task automatic test_random_pack();
    id_ctrl_pkg::slot_types_t types;
    int n;
    test_name = "random_pack";
    // short, short, normal, normal
    feed_bundle(4'b1111, 8'h05);
    #1;
    check_value("first cnt", 3'd2, pipedown_cnt);
    check_value("first lanes", 4'b1111, ir_uop_vld);
    drain_slots();
    for (int b = 0; b < 8; b++) begin
      n = 1 + {lfsr_bit(), lfsr_bit()};
      for (int i = 0; i < `ID_CTRL_SLOTS; i++) types[2*i +: 2] = {1'b0, lfsr_bit()};
      feed_bundle(4'((1 << n) - 1), types);
    end
    drain_slots();
    finish_test();
  endtask

  task automatic test_helper_slot0();
    logic accepted;
    test_name = "helper_slot0";
    fence_stall   = 1'b1;
    fence_uop_vld = 4'b0111;
    feed_bundle(4'b0001, {6'b0, `ID_CTRL_TYPE_FENCE});
    repeat (3) step_cycle(accepted);
    check_value("fence had_pipe_stall", 1'b1, had_pipe_stall);
    fence_stall = 1'b0;
    drain_slots();
    split_long_stall   = 1'b1;
    split_long_uop_vld = 4'b1111;
    feed_bundle(4'b0011, {4'b0, `ID_CTRL_TYPE_NORMAL, `ID_CTRL_TYPE_SPLIT_LONG});
    repeat (3) step_cycle(accepted);
    split_long_stall = 1'b0;
    #1;
    check_value("long split lanes", 4'b1111, ir_uop_vld);
    drain_slots();
    finish_test();
  endtask

  task automatic test_backpressure();
    logic accepted;
    test_name = "backpressure";
    ir_stall       = 1'b1;
    ir_stage_stall = 1'b1;
    feed_bundle(4'b1111, 8'h01);
    repeat (4) step_cycle(accepted);
    ir_stall       = 1'b0;
    ir_stage_stall = 1'b0;
    #1;
    check_value("released cnt", 3'd3, pipedown_cnt);
    check_value("released lanes", 4'b1111, ir_uop_vld);
    drain_slots();
    finish_test();
  endtask

  task automatic test_flush();
    logic accepted;
    test_name = "flush";
    ir_stall = 1'b1;
    feed_bundle(4'b1111, 8'h00);
    iu_cancel = 1'b1;
    step_cycle(accepted);
    iu_cancel = 1'b0;
    step_cycle(accepted);
    feed_bundle(4'b0111, 8'h00);
    rtu_flush = 1'b1;
    step_cycle(accepted);
    rtu_flush = 1'b0;
    ir_stall  = 1'b0;
    #1;
    check_value("id_stall after flush", 1'b0, id_stall);
    check_value("lanes after flush", 4'b0000, ir_uop_vld);
    step_cycle(accepted);
    finish_test();
  endtask

  task automatic test_debug_track();
    logic accepted;
    test_name   = "debug_track";
    hpcp_cnt_en = 1'b1;
    feed_bundle(4'b0011, 8'h00);
    feed_bundle(4'b0111, 8'h00);
    #1;
    check_value("backend stall after drain", 1'b0, hpcp_backend_stall);
    step_cycle(accepted);
    #1;
    check_value("observed valids", 4'b0111, had_inst_vld);
    step_cycle(accepted);
    hpcp_cnt_en  = 1'b0;
    // debug mode alone also tracks drains
    had_debug_en = 1'b1;
    feed_bundle(4'b0001, 8'h00);
    repeat (2) step_cycle(accepted);
    had_debug_en = 1'b0;
    repeat (2) step_cycle(accepted);
    finish_test();
  endtask

  initial begin
    cpurst_b           = 1'b0;
    rtu_flush          = 1'b0;
    iu_cancel          = 1'b0;
    ib_inst_vld        = '0;
    ib_inst_types      = '0;
    ir_stall           = 1'b0;
    ir_stage_stall     = 1'b0;
    fence_stall        = 1'b0;
    fence_uop_vld      = '0;
    split_long_stall   = 1'b0;
    split_long_uop_vld = '0;
    had_debug_en       = 1'b0;
    hpcp_cnt_en        = 1'b0;
    m_vld   = '0;
    m_had   = '0;
    m_types = '0;
    m_dbg   = 1'b0;
    lfsr    = 8'd74;
    test_errors  = 0;
    errors       = 0;
    failed_tests = 0;
    repeat (2) @(posedge debug_id_inst_clk);
    @(negedge debug_id_inst_clk);
    cpurst_b = 1'b1;
    test_reset();
    test_random_pack();
    test_helper_slot0();
    test_backpressure();
    test_flush();
    test_debug_track();
    $display("tests %0d, failed %0d, errors %0d", NUM_TESTS, failed_tests, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end
    else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
+incdir+include
source/id_ctrl_pkg.sv
source/id_decode_slots.sv
source/id_pipedown_sel.sv
source/id_debug_track.sv
source/id_ctrl_top.sv
testbench/tb_id_ctrl.sv
